// ==== build.f ====
hdl/noc_pkg.sv
hdl/na_pkg.sv
hdl/na_fifo.sv
hdl/na_msg_counter.sv
hdl/na_send_fsm.sv
hdl/na_mp_endpoint.sv
tests/na_mp_endpoint_assertions.sv
tests/tb_na_mp_endpoint.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the adapter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_na_mp_endpoint -f build.f
if [ $? -ne 0 ]; then
   echo "run_sim: Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_na_mp_endpoint)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "run_sim: simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^Regression passed$"; then
   echo "run_sim: pass"
   exit 0
fi

echo "run_sim: pass line not found in simulation output"
exit 1

// ==== tests/tb_na_mp_endpoint.sv ====
// Random-stimulus testbench for the message-passing adapter, run as the simulation top
`timescale 1ns/1ps

module tb_na_mp_endpoint;

   import noc_pkg::*;
   import na_pkg::*;

   localparam int NUM_MSGS     = 60;
   localparam int NUM_IN_FLITS = 200;
   // Egress words 60 x 8 times 4 for gaps and stalls and twice that for margin
   localparam int TIMEOUT_CYCLES = 4000;
   // Tail word delay for some messages
   localparam int LONG_GAP = 24;

   logic        clk_i;
   logic        rst_n_i;
   logic [31:0] tx_data_i;
   logic        tx_last_i;
   logic        tx_valid_i;
   logic        tx_ready_o;
   flit_t       noc_out_flit_o;
   logic        noc_out_valid_o;
   logic        noc_out_ready_i;
   flit_t       noc_in_flit_i;
   logic        noc_in_valid_i;
   logic        noc_in_ready_o;
   flit_t       rx_flit_o;
   logic        rx_valid_o;
   logic        rx_ready_i;

   integer      seed;
   // Reference model queues
   flit_t       exp_out_q[$];
   flit_t       exp_rx_q[$];
   logic [31:0] open_msg_q[$];
   // Stimulus state
   int          msgs_done;
   int          msg_len;
   int          word_idx;
   int          tx_gap;
   int          in_flits_done;
   int          in_gap;
   int          cycle_count;
   logic        tx_acc;
   logic        in_acc;
   // Last sampled stall on each output link
   logic        out_stalled;
   flit_t       out_held;
   logic        rx_stalled;
   flit_t       rx_held;

   na_mp_endpoint na_mp_endpoint_inst (.*);

   bind na_mp_endpoint na_mp_endpoint_assertions u_handshake_checks (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .rx_flit_o       (rx_flit_o),
      .rx_valid_o      (rx_valid_o),
      .rx_ready_i      (rx_ready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic int rand_below(input int unsigned n);
      int unsigned r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   function automatic flit_t random_flit();
      flit_t f;
      f.ftype = flit_type_t'(2'(rand_below(4)));
      f.data  = $random(seed);
      return f;
   endfunction

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "Simulation stopped at first failure");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("ERROR at %0d ns: %s expected %0h, actual %0h", $time, name, expected, actual);
         abort_run();
      end
   endtask

   // SINGLE alone, else HEAD, PAYLOAD..., LAST
   task automatic queue_message();
      flit_t f;
      int    n;
      n = open_msg_q.size();
      for (int i = 0; i < n; i++) begin
         f.data = open_msg_q[i];
         if (n == 1) begin
            f.ftype = SINGLE;
         end else if (i == 0) begin
            f.ftype = HEAD;
         end else if (i == n - 1) begin
            f.ftype = LAST;
         end else begin
            f.ftype = PAYLOAD;
         end
         exp_out_q.push_back(f);
      end
      open_msg_q.delete();
   endtask

   // Runs between edges, where every output has settled
   task automatic sample_and_check();
      int egress_words;
      egress_words = open_msg_q.size() + exp_out_q.size();
      // Ready and valid follow model occupancy
      check_value("tx_ready_o", 64'(egress_words < EGRESS_DEPTH), 64'(tx_ready_o));
      check_value("noc_in_ready_o", 64'(exp_rx_q.size() < INGRESS_DEPTH), 64'(noc_in_ready_o));
      check_value("rx_valid_o", 64'(exp_rx_q.size() != 0), 64'(rx_valid_o));
      if (out_stalled) begin
         check_value("noc_out_valid_o", 64'(1), 64'(noc_out_valid_o));
         check_value("noc_out_flit_o", 64'(out_held), 64'(noc_out_flit_o));
      end
      if (rx_stalled) begin
         check_value("rx_valid_o", 64'(1), 64'(rx_valid_o));
         check_value("rx_flit_o", 64'(rx_held), 64'(rx_flit_o));
      end
      out_stalled = noc_out_valid_o && !noc_out_ready_i;
      out_held    = noc_out_flit_o;
      rx_stalled  = rx_valid_o && !rx_ready_i;
      rx_held     = rx_flit_o;
      // Output checked before this edge's push, so an early flit finds nothing queued
      if (noc_out_valid_o && noc_out_ready_i) begin
         if (exp_out_q.size() == 0) begin
            $display("Output flit %0h sent before its message was fully pushed", noc_out_flit_o);
            abort_run();
         end else begin
            check_value("noc_out_flit_o", 64'(exp_out_q[0]), 64'(noc_out_flit_o));
            void'(exp_out_q.pop_front());
         end
      end
      tx_acc = tx_valid_i && tx_ready_o;
      if (tx_acc) begin
         open_msg_q.push_back(tx_data_i);
         if (tx_last_i) begin
            queue_message();
         end
      end
      if (rx_valid_o && rx_ready_i) begin
         check_value("rx_flit_o", 64'(exp_rx_q[0]), 64'(rx_flit_o));
         void'(exp_rx_q.pop_front());
      end
      in_acc = noc_in_valid_i && noc_in_ready_o;
      if (in_acc) begin
         exp_rx_q.push_back(noc_in_flit_i);
      end
   endtask

   // First word of each message is its destination word
   task automatic drive_tx();
      if (tx_acc) begin
         word_idx++;
         if (word_idx == msg_len) begin
            msgs_done++;
            word_idx = 0;
            msg_len  = 0;
            tx_gap   = rand_below(4);
         end else if ((word_idx == msg_len - 1) && (msgs_done % 5 == 2)) begin
            tx_gap = LONG_GAP;
         end else begin
            tx_gap = (rand_below(3) == 0) ? rand_below(4) : 0;
         end
      end
      if (!tx_valid_i || tx_acc) begin
         if (tx_gap > 0 || msgs_done == NUM_MSGS) begin
            tx_gap = (tx_gap > 0) ? tx_gap - 1 : 0;
            tx_valid_i <= 1'b0;
         end else begin
            if (msg_len == 0) begin
               msg_len = 1 + rand_below(MAX_MSG_WORDS);
            end
            tx_valid_i <= 1'b1;
            tx_data_i  <= $random(seed);
            tx_last_i  <= (word_idx == msg_len - 1);
         end
      end
   endtask

   task automatic drive_noc_in();
      if (in_acc) begin
         in_flits_done++;
         in_gap = (rand_below(2) == 0) ? rand_below(5) : 0;
      end
      if (!noc_in_valid_i || in_acc) begin
         if (in_gap > 0 || in_flits_done == NUM_IN_FLITS) begin
            in_gap = (in_gap > 0) ? in_gap - 1 : 0;
            noc_in_valid_i <= 1'b0;
         end else begin
            noc_in_valid_i <= 1'b1;
            noc_in_flit_i  <= random_flit();
         end
      end
   endtask

   initial begin
      seed            = 73326;
      rst_n_i         = 1'b0;
      tx_data_i       = '0;
      tx_last_i       = 1'b0;
      tx_valid_i      = 1'b0;
      noc_out_ready_i = 1'b0;
      noc_in_flit_i   = '0;
      noc_in_valid_i  = 1'b0;
      rx_ready_i      = 1'b0;
      msgs_done       = 0;
      msg_len         = 0;
      word_idx        = 0;
      tx_gap          = 0;
      in_flits_done   = 0;
      in_gap          = 0;
      cycle_count     = 0;
      tx_acc          = 1'b0;
      in_acc          = 1'b0;
      out_stalled     = 1'b0;
      rx_stalled      = 1'b0;
      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      // Idle outputs after reset
      check_value("noc_out_valid_o", 64'(0), 64'(noc_out_valid_o));
      check_value("rx_valid_o", 64'(0), 64'(rx_valid_o));
      check_value("tx_ready_o", 64'(1), 64'(tx_ready_o));
      check_value("noc_in_ready_o", 64'(1), 64'(noc_in_ready_o));
      while (!(msgs_done == NUM_MSGS && in_flits_done == NUM_IN_FLITS &&
               exp_out_q.size() == 0 && exp_rx_q.size() == 0)) begin
         @(posedge clk_i);
         drive_tx();
         drive_noc_in();
         // About 30 percent stall on each output link
         noc_out_ready_i <= (rand_below(10) >= 3);
         rx_ready_i      <= (rand_below(10) >= 3);
         @(negedge clk_i);
         cycle_count++;
         if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: traffic still pending after %0d cycles", cycle_count);
            abort_run();
         end
         sample_and_check();
      end
      $display("Regression passed");
      $finish;
   end

endmodule

// ==== tests/na_mp_endpoint_assertions.sv ====
// Concurrent handshake checks on the adapter top level, attached to it by a bind in the testbench
`timescale 1ns/1ps

module na_mp_endpoint_assertions (
   input logic           clk_i,
   input logic           rst_n_i,
   input noc_pkg::flit_t noc_out_flit_o,
   input logic           noc_out_valid_o,
   input logic           noc_out_ready_i,
   input noc_pkg::flit_t rx_flit_o,
   input logic           rx_valid_o,
   input logic           rx_ready_i
);

   // Stalled NoC output keeps its flit until taken
   out_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (noc_out_valid_o && !noc_out_ready_i) |=> (noc_out_valid_o && $stable(noc_out_flit_o)))
      else $error("NoC output flit dropped or changed while stalled");

   // Same rule on the core receive side
   rx_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (rx_valid_o && !rx_ready_i) |=> (rx_valid_o && $stable(rx_flit_o)))
      else $error("Receive flit dropped or changed while stalled");

   // Nothing offered right after reset release
   quiet_after_reset: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> (!noc_out_valid_o && !rx_valid_o))
      else $error("Valid output high in the first cycle after reset");

endmodule

// ==== hdl/na_mp_endpoint.sv ====
// Message-passing network adapter top level for one tile, joining egress and ingress paths
`timescale 1ns/1ps

module na_mp_endpoint (
   input  logic           clk_i,
   input  logic           rst_n_i,
   // Core transmit
   input  logic [31:0]    tx_data_i,
   input  logic           tx_last_i,
   input  logic           tx_valid_i,
   output logic           tx_ready_o,
   // NoC output
   output noc_pkg::flit_t noc_out_flit_o,
   output logic           noc_out_valid_o,
   input  logic           noc_out_ready_i,
   // NoC input
   input  noc_pkg::flit_t noc_in_flit_i,
   input  logic           noc_in_valid_i,
   output logic           noc_in_ready_o,
   // Core receive
   output noc_pkg::flit_t rx_flit_o,
   output logic           rx_valid_o,
   input  logic           rx_ready_i
);

   import noc_pkg::*;
   import na_pkg::*;

   egress_word_t tx_word;
   egress_word_t egress_head;
   logic         egress_full;
   logic         egress_empty;
   logic         egress_pop;
   logic         ingress_full;
   logic         ingress_empty;
   logic         msg_queued;
   logic         msg_sent;
   logic         msg_pending;

   // Egress path
   assign tx_word.last = tx_last_i;
   assign tx_word.data = tx_data_i;
   assign tx_ready_o   = !egress_full;

   // Accepted tail word completes a message
   assign msg_queued = tx_valid_i && tx_ready_o && tx_last_i;

   na_fifo #(
      .payload_t (egress_word_t),
      .DEPTH     (EGRESS_DEPTH)
   ) u_egress_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (tx_valid_i),
      .push_data_i (tx_word),
      .full_o      (egress_full),
      .pop_i       (egress_pop),
      .head_o      (egress_head),
      .empty_o     (egress_empty)
   );

   na_msg_counter u_msg_counter (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .msg_queued_i  (msg_queued),
      .msg_sent_i    (msg_sent),
      .msg_pending_o (msg_pending)
   );

   na_send_fsm u_send_fsm (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .msg_pending_i   (msg_pending),
      .word_i          (egress_head),
      .word_empty_i    (egress_empty),
      .word_pop_o      (egress_pop),
      .msg_sent_o      (msg_sent),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i)
   );

   // Ingress flits pass through untouched
   assign noc_in_ready_o = !ingress_full;
   assign rx_valid_o     = !ingress_empty;

   na_fifo #(
      .payload_t (flit_t),
      .DEPTH     (INGRESS_DEPTH)
   ) u_ingress_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (noc_in_valid_i),
      .push_data_i (noc_in_flit_i),
      .full_o      (ingress_full),
      .pop_i       (rx_ready_i),
      .head_o      (rx_flit_o),
      .empty_o     (ingress_empty)
   );

endmodule

// ==== hdl/na_send_fsm.sv ====
// Egress FSM turning queued words into typed flits on the NoC output link
`timescale 1ns/1ps

module na_send_fsm (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   // From message counter
   input  logic                 msg_pending_i,
   // Egress FIFO head
   input  na_pkg::egress_word_t word_i,
   input  logic                 word_empty_i,
   output logic                 word_pop_o,
   // End of message pulse to counter
   output logic                 msg_sent_o,
   // NoC output link
   output noc_pkg::flit_t       noc_out_flit_o,
   output logic                 noc_out_valid_o,
   input  logic                 noc_out_ready_i
);

   import noc_pkg::*;
   import na_pkg::*;

   send_state_t state;
   send_state_t state_next;
   logic        xfer;

   // Offer a flit whenever a packet is open and a word waits
   assign noc_out_valid_o = ((state == FIRST) || (state == BODY)) && !word_empty_i;
   assign xfer            = noc_out_valid_o && noc_out_ready_i;

   // One word leaves the FIFO per link transfer
   assign word_pop_o = xfer;
   assign msg_sent_o = xfer && word_i.last;

   // Flit labelling
   always_comb begin
      noc_out_flit_o.data  = word_i.data;
      noc_out_flit_o.ftype = PAYLOAD;
      if (state == FIRST) begin
         noc_out_flit_o.ftype = word_i.last ? SINGLE : HEAD;
      end else if (word_i.last) begin
         noc_out_flit_o.ftype = LAST;
      end
   end

   // Next state
   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            // FIRST follows one cycle after the count turns nonzero
            if (msg_pending_i) begin
               state_next = FIRST;
            end
         end
         FIRST: begin
            if (xfer) begin
               state_next = word_i.last ? IDLE : BODY;
            end
         end
         BODY: begin
            if (xfer && word_i.last) begin
               state_next = IDLE;
            end
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

endmodule

// ==== hdl/na_msg_counter.sv ====
// Up/down counter of complete messages waiting in the egress FIFO, gating the send FSM
`timescale 1ns/1ps

module na_msg_counter (
   input  logic clk_i,
   input  logic rst_n_i,
   // Pulse per push carrying a last word
   input  logic msg_queued_i,
   // Pulse per sent LAST or SINGLE flit
   input  logic msg_sent_i,
   // At least one whole message queued
   output logic msg_pending_o
);

   import na_pkg::*;

   logic [MSG_COUNT_WIDTH-1:0] msg_count;

   // Both pulses on one edge cancel out
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         msg_count <= '0;
      end else if (msg_queued_i && !msg_sent_i) begin
         msg_count <= msg_count + 1'b1;
      end else if (msg_sent_i && !msg_queued_i) begin
         msg_count <= msg_count - 1'b1;
      end
   end

   // Keeps the FSM from opening a packet whose tail is not yet written
   assign msg_pending_o = (msg_count != '0);

endmodule

// ==== hdl/na_fifo.sv ====
// First-word-fall-through FIFO with a type parameter, used for egress words and ingress flits
`timescale 1ns/1ps

module na_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 4
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   // Push side
   input  logic     push_i,
   input  payload_t push_data_i,
   output logic     full_o,
   // Pop side
   input  logic     pop_i,
   output payload_t head_o,
   output logic     empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // Requests are ignored when they cannot be honored
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);

   // Head visible without a pop
   assign head_o = mem[rd_ptr];

   // Storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // Pointers wrap at DEPTH which need not be a power of two
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== hdl/na_pkg.sv ====
// Adapter sizing, egress word format and send states, imported by the adapter RTL and testbench
package na_pkg;

   // Egress buffer in words
   localparam int EGRESS_DEPTH = 16;

   // Ingress buffer in flits
   localparam int INGRESS_DEPTH = 4;

   // Longest message the core may push
   // Must stay within EGRESS_DEPTH so a whole message always fits
   localparam int MAX_MSG_WORDS = 8;

   // Counts 0 up to EGRESS_DEPTH complete messages
   localparam int MSG_COUNT_WIDTH = $clog2(EGRESS_DEPTH + 1);

   // One queued word plus its end-of-message flag
   typedef struct packed {
      logic                                last;
      logic [noc_pkg::FLIT_DATA_WIDTH-1:0] data;
   } egress_word_t;

   // Egress FSM states
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      FIRST = 2'd1,
      BODY  = 2'd2
   } send_state_t;

endpackage

// ==== hdl/noc_pkg.sv ====
// Link-level flit format for the NoC port, imported by the adapter RTL and its testbench
package noc_pkg;

   // Payload bits carried by every flit
   localparam int FLIT_DATA_WIDTH = 32;

   // Position code width on the link
   localparam int FLIT_TYPE_WIDTH = 2;

   // Total flit width on the wire
   localparam int FLIT_WIDTH = FLIT_TYPE_WIDTH + FLIT_DATA_WIDTH;

   // Bit 0 marks the start of a packet, bit 1 its end
   // A one-flit packet sets both
   typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
      PAYLOAD = 2'b00,
      LAST    = 2'b10,
      HEAD    = 2'b01,
      SINGLE  = 2'b11
   } flit_type_t;

   // Type sits in the upper bits, data below
   typedef struct packed {
      flit_type_t                 ftype;
      logic [FLIT_DATA_WIDTH-1:0] data;
   } flit_t;

endpackage
